/* logic/dbg_pkg.sv */
// debug word and memory request types, data and address widths, select-0 field positions
`default_nettype none

package dbg_pkg;

	// data path and memory address widths
	localparam int dbg_data_w = 32;
	localparam int dbg_addr_w = 8;

	// select-0 word layout
	localparam int dbg_addr_lsb = 0;
	localparam int dbg_addr_msb = dbg_addr_lsb + dbg_addr_w - 1; // bits 7:0
	localparam int dbg_rd_bit   = 8; // read request flag

	// one captured DR word
	typedef struct packed {
		logic                  sel;  // 0 for IR 0x32, 1 for IR 0x38
		logic [dbg_data_w-1:0] data;
	} dbg_word_t;

	// one memory access as presented by either master
	typedef struct packed {
		logic                  we;
		logic [dbg_addr_w-1:0] addr;
		logic [dbg_data_w-1:0] wdata; // ignored on reads
	} mem_req_t;

endpackage

`default_nettype wire

/* logic/jtag_dr_capture.sv */
// JTAG data register capture: jtck oversampling, DR shift, select latch, update strobe
`default_nettype none

module jtag_dr_capture import dbg_pkg::*; (
	input  logic      clk48m,
	input  logic      jrstn,
	input  logic      jtck,
	input  logic      jtdi,
	input  logic      jshift,
	input  logic      jupdate,
	input  logic      jce1,
	input  logic      jce2,
	output dbg_word_t dbgreg,
	output logic      dbgreg_strobe
);

	logic [3:0]            tck_shift;  // jtck history, bit 0 newest
	logic                  tck_rise;
	logic                  old_jshift; // jshift seen at the previous action point
	logic                  dr_sel;
	logic [dbg_data_w-1:0] dr_shift;

	// act a few cycles after the rising edge so TAP outputs have settled
	assign tck_rise = tck_shift[2] && !tck_shift[3];

	always_ff @(posedge clk48m) begin
		if (!jrstn) begin
			tck_shift     <= '0;
			old_jshift    <= 1'b0;
			dr_sel        <= 1'b0;
			dbgreg_strobe <= 1'b0;
		end else begin
			tck_shift     <= {tck_shift[2:0], jtck};
			dbgreg_strobe <= tck_rise && jupdate;
			if (tck_rise) begin
				old_jshift <= jshift;
				if (jce1 || jce2) begin
					dr_sel <= jce2; // jce2 marks the IR 0x38 register
				end
			end
		end
	end

	// shift register and captured word
	always_ff @(posedge clk48m) begin
		if (tck_rise && old_jshift) begin
			dr_shift <= {jtdi, dr_shift[dbg_data_w-1:1]}; // lsb first, enters at the top
		end
		if (tck_rise && jupdate) begin
			dbgreg.sel  <= dr_sel;
			dbgreg.data <= dr_shift; // value before this edge's shift
		end
	end

endmodule

`default_nettype wire

/* logic/dbg_cmd_decode.sv */
// debug command decoder: address register, read and auto-incrementing write requests, read data hold
`default_nettype none

module dbg_cmd_decode import dbg_pkg::*; (
	input  logic                  clk48m,
	input  logic                  jrstn,
	input  dbg_word_t             dbgreg,
	input  logic                  dbgreg_strobe,
	input  logic                  dbg_grant,
	input  logic                  dbg_rvalid_in,
	input  logic [dbg_data_w-1:0] mem_rdata,
	output logic                  dbg_req,
	output mem_req_t              dbg_cmd,
	output logic [dbg_data_w-1:0] dbg_rdata,
	output logic                  dbg_rvalid,
	output logic                  dbg_overrun
);

	logic [dbg_addr_w-1:0] addr;       // debug address pointer
	logic                  req_we;
	logic [dbg_data_w-1:0] req_wdata;
	logic [dbg_data_w-1:0] rdata_hold;
	logic                  accept;
	logic                  rd_flag;

	// a request still waiting for its grant blocks new words
	assign accept  = dbgreg_strobe && !(dbg_req && !dbg_grant);
	assign rd_flag = dbgreg.data[dbg_rd_bit];

	always_ff @(posedge clk48m) begin
		if (!jrstn) begin
			addr        <= '0;
			dbg_req     <= 1'b0;
			req_we      <= 1'b0;
			dbg_overrun <= 1'b0;
		end else begin
			dbg_overrun <= dbgreg_strobe && !accept;

			// a fresh address load takes precedence over the increment
			if (accept && !dbgreg.sel) begin
				addr <= dbgreg.data[dbg_addr_msb:dbg_addr_lsb];
			end else if (dbg_grant && req_we) begin
				addr <= addr + 1'b1; // wraps with the register width
			end

			if (accept && (dbgreg.sel || rd_flag)) begin
				dbg_req <= 1'b1;
				req_we  <= dbgreg.sel;
			end else if (dbg_grant) begin
				dbg_req <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk48m) begin
		if (accept && dbgreg.sel) begin
			req_wdata <= dbgreg.data;
		end
		if (dbg_rvalid_in) begin
			rdata_hold <= mem_rdata;
		end
	end

	// address is stable while the request is pending
	assign dbg_cmd = '{we: req_we, addr: addr, wdata: req_wdata};

	// data shows up with its valid pulse, then stays put
	assign dbg_rdata  = dbg_rvalid_in ? mem_rdata : rdata_hold;
	assign dbg_rvalid = dbg_rvalid_in;

endmodule

`default_nettype wire

/* logic/mem_arbiter.sv */
// round-robin memory arbiter for the debug and host masters, with read data ownership
`default_nettype none

module mem_arbiter import dbg_pkg::*; #(
	parameter int mem_depth = 256
) (
	input  logic     clk48m,
	input  logic     jrstn,
	input  logic     dbg_req,
	input  mem_req_t dbg_cmd,
	input  logic     host_req,
	input  mem_req_t host_cmd,
	output logic     dbg_grant,
	output logic     host_grant,
	output logic     dbg_rvalid,
	output logic     host_rvalid,
	output logic     mem_en,
	output mem_req_t mem_cmd
);

	logic     rd_busy;   // read data cycle, port not available
	logic     rd_owner;  // 1 when the host owns the pending read data
	logic     last_host; // last winner was the host
	mem_req_t sel_cmd;

	always_comb begin
		dbg_grant  = 1'b0;
		host_grant = 1'b0;
		if (!rd_busy) begin
			if (dbg_req && (!host_req || last_host)) begin
				dbg_grant = 1'b1;
			end else if (host_req) begin
				host_grant = 1'b1;
			end
		end
	end

	assign mem_en  = dbg_grant || host_grant;
	assign sel_cmd = host_grant ? host_cmd : dbg_cmd;

	// address wraps to the memory depth
	always_comb begin
		mem_cmd      = sel_cmd;
		mem_cmd.addr = dbg_addr_w'(sel_cmd.addr % mem_depth);
	end

	always_ff @(posedge clk48m) begin
		if (!jrstn) begin
			rd_busy   <= 1'b0;
			rd_owner  <= 1'b0;
			last_host <= 1'b1; // debug master goes first after reset
		end else begin
			rd_busy <= mem_en && !mem_cmd.we;
			if (mem_en) begin
				rd_owner  <= host_grant;
				last_host <= host_grant;
			end
		end
	end

	assign dbg_rvalid  = rd_busy && !rd_owner;
	assign host_rvalid = rd_busy && rd_owner;

endmodule

`default_nettype wire

/* logic/dbg_ram.sv */
// single-port debug memory with registered read data
`default_nettype none

module dbg_ram import dbg_pkg::*; #(
	parameter int mem_depth = 256
) (
	input  logic                  clk48m,
	input  logic                  mem_en,
	input  mem_req_t              mem_cmd,
	output logic [dbg_data_w-1:0] mem_rdata
);

	localparam int mem_aw = $clog2(mem_depth);

	logic [dbg_data_w-1:0] mem [mem_depth]; // maps to block RAM

	always_ff @(posedge clk48m) begin
		if (mem_en) begin
			if (mem_cmd.we) begin
				mem[mem_cmd.addr[mem_aw-1:0]] <= mem_cmd.wdata;
			end else begin
				mem_rdata <= mem[mem_cmd.addr[mem_aw-1:0]]; // valid next cycle
			end
		end
	end

endmodule

`default_nettype wire

/* logic/dbg_subsys_top.sv */
// debug register subsystem top: JTAG capture, command decode, arbiter and debug memory
`default_nettype none

module dbg_subsys_top import dbg_pkg::*; #(
	parameter int mem_depth = 256
) (
	input  logic                  clk48m,
	input  logic                  jrstn,
	input  logic                  jtck,
	input  logic                  jtdi,
	input  logic                  jshift,
	input  logic                  jupdate,
	input  logic                  jce1,
	input  logic                  jce2,
	input  logic                  host_req,
	input  mem_req_t              host_cmd,
	output logic                  host_grant,
	output logic [dbg_data_w-1:0] host_rdata,
	output logic                  host_rvalid,
	output logic [dbg_data_w-1:0] dbg_rdata,
	output logic                  dbg_rvalid,
	output logic                  dbg_overrun
);

	dbg_word_t             dbgreg;
	logic                  dbgreg_strobe;
	logic                  dbg_req;
	mem_req_t              dbg_cmd;
	logic                  dbg_grant;
	logic                  arb_dbg_rvalid; // read data owned by the debug master
	logic                  mem_en;
	mem_req_t              mem_cmd;
	logic [dbg_data_w-1:0] mem_rdata;

	jtag_dr_capture u_capture (
		.clk48m        (clk48m),
		.jrstn         (jrstn),
		.jtck          (jtck),
		.jtdi          (jtdi),
		.jshift        (jshift),
		.jupdate       (jupdate),
		.jce1          (jce1),
		.jce2          (jce2),
		.dbgreg        (dbgreg),
		.dbgreg_strobe (dbgreg_strobe)
	);

	dbg_cmd_decode u_decode (
		.clk48m        (clk48m),
		.jrstn         (jrstn),
		.dbgreg        (dbgreg),
		.dbgreg_strobe (dbgreg_strobe),
		.dbg_grant     (dbg_grant),
		.dbg_rvalid_in (arb_dbg_rvalid),
		.mem_rdata     (mem_rdata),
		.dbg_req       (dbg_req),
		.dbg_cmd       (dbg_cmd),
		.dbg_rdata     (dbg_rdata),
		.dbg_rvalid    (dbg_rvalid),
		.dbg_overrun   (dbg_overrun)
	);

	mem_arbiter #(
		.mem_depth (mem_depth)
	) u_arbiter (
		.clk48m      (clk48m),
		.jrstn       (jrstn),
		.dbg_req     (dbg_req),
		.dbg_cmd     (dbg_cmd),
		.host_req    (host_req),
		.host_cmd    (host_cmd),
		.dbg_grant   (dbg_grant),
		.host_grant  (host_grant),
		.dbg_rvalid  (arb_dbg_rvalid),
		.host_rvalid (host_rvalid),
		.mem_en      (mem_en),
		.mem_cmd     (mem_cmd)
	);

	dbg_ram #(
		.mem_depth (mem_depth)
	) u_ram (
		.clk48m    (clk48m),
		.mem_en    (mem_en),
		.mem_cmd   (mem_cmd),
		.mem_rdata (mem_rdata)
	);

	assign host_rdata = mem_rdata; // shared read bus, host_rvalid marks ownership

endmodule

`default_nettype wire

/* sim/dbg_subsys_props.sv */
// arbiter properties for exclusive grants, a free port after each read and rvalid timing
`default_nettype none

module dbg_subsys_props import dbg_pkg::*; (
	input wire logic     clk48m,
	input wire logic     jrstn,
	input wire logic     dbg_grant,
	input wire logic     host_grant,
	input wire logic     dbg_rvalid,
	input wire logic     host_rvalid,
	input wire logic     mem_en,
	input wire mem_req_t mem_cmd
);

	int assert_errs = 0; // failed assertions so far

	a_one_grant: assert property (@(posedge clk48m) disable iff (!jrstn)
		!(dbg_grant && host_grant))
		else begin
			$error("debug and host granted in the same cycle");
			assert_errs++;
		end

	// port is reserved while read data comes back
	a_busy_no_grant: assert property (@(posedge clk48m) disable iff (!jrstn)
		(mem_en && !mem_cmd.we) |=> !(dbg_grant || host_grant))
		else begin
			$error("grant given in a read data cycle");
			assert_errs++;
		end

	a_dbg_rvalid: assert property (@(posedge clk48m) disable iff (!jrstn)
		(dbg_grant && !mem_cmd.we) |=> dbg_rvalid)
		else begin
			$error("dbg_rvalid missing one cycle after a debug read grant");
			assert_errs++;
		end

	a_host_rvalid: assert property (@(posedge clk48m) disable iff (!jrstn)
		(host_grant && !mem_cmd.we) |=> host_rvalid)
		else begin
			$error("host_rvalid missing one cycle after a host read grant");
			assert_errs++;
		end

	a_dbg_rvalid_src: assert property (@(posedge clk48m) disable iff (!jrstn)
		dbg_rvalid |-> $past(dbg_grant && !mem_cmd.we))
		else begin
			$error("dbg_rvalid without a debug read grant before it");
			assert_errs++;
		end

	a_host_rvalid_src: assert property (@(posedge clk48m) disable iff (!jrstn)
		host_rvalid |-> $past(host_grant && !mem_cmd.we))
		else begin
			$error("host_rvalid without a host read grant before it");
			assert_errs++;
		end

endmodule

bind mem_arbiter dbg_subsys_props u_props (
	.clk48m      (clk48m),
	.jrstn       (jrstn),
	.dbg_grant   (dbg_grant),
	.host_grant  (host_grant),
	.dbg_rvalid  (dbg_rvalid),
	.host_rvalid (host_rvalid),
	.mem_en      (mem_en),
	.mem_cmd     (mem_cmd)
);

`default_nettype wire

/* sim/dbg_subsys_tb.sv */
// debug subsystem testbench with JTAG bit-bang, host port, stimulus table and memory model
`default_nettype none

module dbg_subsys_tb import dbg_pkg::*; ();

	typedef enum logic [2:0] {
		op_sel0, op_sel1, op_host_wr, op_host_rd, op_both_wr, op_both_rd
	} op_t;

	typedef struct packed {
		op_t         op;
		logic [7:0]  addr;  // sel0 load address or host address
		logic [31:0] data;
		logic        rd;    // read flag of a sel0 word
		logic        rnd;   // data comes from $random
		logic [31:0] exp;   // filled by the memory model
	} row_t;

	localparam int num_rows = 18;
	localparam int cycle_limit = (num_rows * 40 * 8 + 200) * 3 / 2;

	logic                  clk48m = 1'b0;
	logic                  jrstn;
	logic                  jtck, jtdi, jshift, jupdate, jce1, jce2;
	logic                  host_req;
	mem_req_t              host_cmd;
	logic                  host_grant, host_rvalid, dbg_rvalid, dbg_overrun;
	logic [dbg_data_w-1:0] host_rdata, dbg_rdata;

	row_t                  tbl [num_rows];
	logic [31:0]           ref_mem [256];
	logic [7:0]            ref_addr;
	int                    seed = 32'hb1c1;
	int                    err_value = 0;
	int                    err_missing = 0;
	int                    err_assert = 0;
	int                    cycles = 0;
	int                    dbg_rvalid_cyc = 0; // cycle of the latest dbg_rvalid
	int                    host_grant_cyc = 0; // cycle of the latest host grant
	logic                  dbg_got;
	logic [31:0]           dbg_got_data;
	logic                  overrun_seen = 1'b0;

	dbg_subsys_top #(.mem_depth(256)) UUT (
		.clk48m      (clk48m),
		.jrstn       (jrstn),
		.jtck        (jtck),
		.jtdi        (jtdi),
		.jshift      (jshift),
		.jupdate     (jupdate),
		.jce1        (jce1),
		.jce2        (jce2),
		.host_req    (host_req),
		.host_cmd    (host_cmd),
		.host_grant  (host_grant),
		.host_rdata  (host_rdata),
		.host_rvalid (host_rvalid),
		.dbg_rdata   (dbg_rdata),
		.dbg_rvalid  (dbg_rvalid),
		.dbg_overrun (dbg_overrun)
	);

	always #4 clk48m = ~clk48m;

	// run limit
	always @(posedge clk48m) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("run timed out after %0d cycles", cycles);
			$display("test failed");
			$finish;
		end
	end

	// debug read data and overrun are caught whenever they happen
	always @(negedge clk48m) begin
		if (dbg_rvalid) begin
			dbg_got        = 1'b1;
			dbg_got_data   = dbg_rdata;
			dbg_rvalid_cyc = cycles;
		end
		if (dbg_overrun) overrun_seen = 1'b1;
	end

	task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string msg);
		if (got !== exp) begin
			$display("ERR %0t: %s: got %h expected %h", $time, msg, got, exp);
			err_value++;
		end
	endtask

	task automatic check_cmd(input mem_req_t got, input mem_req_t exp, input string msg);
		if (got !== exp) begin
			$display("ERR %0t: %s: got we=%b addr=%h wdata=%h expected we=%b addr=%h wdata=%h",
				$time, msg, got.we, got.addr, got.wdata, exp.we, exp.addr, exp.wdata);
			err_value++;
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string msg);
		if (got !== exp) begin
			$display("ERR %0t: %s: got %b expected %b", $time, msg, got, exp);
			err_value++;
		end
	endtask

	// one jtck period of 8 clk48m cycles with the inputs held throughout
	task automatic jtck_cycle(input logic tdi, input logic sh, input logic upd,
			input logic ce1, input logic ce2);
		jtdi    <= tdi;
		jshift  <= sh;
		jupdate <= upd;
		jce1    <= ce1;
		jce2    <= ce2;
		jtck    <= 1'b1;
		repeat (4) @(posedge clk48m);
		jtck <= 1'b0;
		repeat (4) @(posedge clk48m);
	endtask

	// select, 32 shift bits lsb first, update, one idle period
	task automatic jtag_shift_word(input logic sel, input logic [31:0] word);
		jtck_cycle(1'b0, 1'b1, 1'b0, !sel, sel);
		for (int i = 0; i < 32; i++) begin
			jtck_cycle(word[i], i != 31, 1'b0, !sel, sel);
		end
		jtck_cycle(1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
		jtck_cycle(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
	endtask

	task automatic jtag_read(input logic [7:0] addr, input logic [31:0] exp);
		int n;
		n = 0;
		dbg_got = 1'b0;
		jtag_shift_word(1'b0, 32'(addr) | (32'd1 << dbg_rd_bit));
		while (!dbg_got && n < 64) begin
			@(posedge clk48m);
			n++;
		end
		if (dbg_got) check_word(dbg_got_data, exp, "debug read data");
		else begin
			$display("no read data arrived for the debug read of address %h", addr);
			err_missing++;
		end
	endtask

	task automatic host_write(input logic [7:0] addr, input logic [31:0] data);
		mem_req_t cmd;
		int       n;
		cmd = '{we: 1'b1, addr: addr, wdata: data};
		n = 0;
		host_req <= 1'b1;
		host_cmd <= cmd;
		do begin
			@(negedge clk48m);
			n++;
		end while (!host_grant && n < 200);
		if (host_grant) check_cmd(UUT.mem_cmd, cmd, "host write at memory port");
		else $display("host write to %h was never granted", addr);
		if (!host_grant) err_missing++;
		@(posedge clk48m);
		host_req <= 1'b0;
	endtask

	// back to back reads with host_req held high
	task automatic host_read_burst(input logic [7:0] base, input int cnt);
		mem_req_t cmd;
		logic     pending;
		logic     granted;
		logic [7:0] paddr;
		int       k, n;
		k = 0;
		n = 0;
		pending = 1'b0;
		paddr = base;
		cmd = '{we: 1'b0, addr: base, wdata: '0};
		host_req <= 1'b1;
		host_cmd <= cmd;
		while ((k < cnt || pending) && n < 200) begin
			@(negedge clk48m);
			n++;
			granted = host_grant;
			if (pending) begin
				if (host_rvalid) check_word(host_rdata, ref_mem[paddr], "host read data");
				else begin
					$display("no read data arrived for the host read of address %h", paddr);
					err_missing++;
				end
				pending = 1'b0;
			end
			if (granted) begin
				check_cmd(UUT.mem_cmd, cmd, "host read at memory port");
				pending = 1'b1;
				paddr = cmd.addr;
				host_grant_cyc = cycles;
			end
			@(posedge clk48m);
			if (granted) begin
				k++;
				cmd.addr = base + 8'(k);
				if (k < cnt) host_cmd <= cmd; // next command in the cycle after the grant
				else host_req <= 1'b0;
			end
		end
		if (k < cnt) begin
			$display("host reads from %h were not all granted", base);
			err_missing++;
		end
	endtask

	task automatic build_table();
		tbl[0]  = '{op_sel0,    8'h10, 32'h0, 1'b0, 1'b0, 32'h0};
		tbl[1]  = '{op_sel1,    8'h00, 32'h0, 1'b0, 1'b1, 32'h0};
		tbl[2]  = '{op_sel1,    8'h00, 32'h0, 1'b0, 1'b1, 32'h0};
		tbl[3]  = '{op_sel1,    8'h00, 32'h0, 1'b0, 1'b1, 32'h0};
		tbl[4]  = '{op_host_rd, 8'h10, 32'h0, 1'b0, 1'b0, 32'h0};
		tbl[5]  = '{op_host_rd, 8'h11, 32'h0, 1'b0, 1'b0, 32'h0};
		tbl[6]  = '{op_host_rd, 8'h12, 32'h0, 1'b0, 1'b0, 32'h0};
		tbl[7]  = '{op_host_wr, 8'h40, 32'h0, 1'b0, 1'b1, 32'h0};
		tbl[8]  = '{op_sel0,    8'h40, 32'h0, 1'b1, 1'b0, 32'h0};
		tbl[9]  = '{op_both_wr, 8'h10, 32'h0, 1'b0, 1'b1, 32'h0}; // host reads 0x10.. meanwhile
		tbl[10] = '{op_host_rd, 8'h40, 32'h0, 1'b0, 1'b0, 32'h0};
		tbl[11] = '{op_both_rd, 8'h11, 32'h0, 1'b1, 1'b0, 32'h0};
		tbl[12] = '{op_sel0,    8'hff, 32'h0, 1'b0, 1'b0, 32'h0};
		tbl[13] = '{op_sel1,    8'h00, 32'h0, 1'b0, 1'b1, 32'h0};
		tbl[14] = '{op_sel1,    8'h00, 32'h0, 1'b0, 1'b1, 32'h0}; // lands at 0x00
		tbl[15] = '{op_host_rd, 8'h00, 32'h0, 1'b0, 1'b0, 32'h0};
		tbl[16] = '{op_host_rd, 8'hff, 32'h0, 1'b0, 1'b0, 32'h0};
		tbl[17] = '{op_sel0,    8'h00, 32'h0, 1'b1, 1'b0, 32'h0};
		for (int i = 0; i < num_rows; i++) begin
			if (tbl[i].rnd) tbl[i].data = $random(seed);
		end
	endtask

	task automatic apply_row(input int i);
		row_t r;
		r = tbl[i];
		case (r.op)
			op_sel0: begin
				ref_addr = r.addr;
				if (r.rd) begin
					tbl[i].exp = ref_mem[ref_addr];
					jtag_read(r.addr, tbl[i].exp);
				end else begin
					jtag_shift_word(1'b0, 32'(r.addr));
				end
			end
			op_sel1: begin
				ref_mem[ref_addr] = r.data;
				ref_addr = ref_addr + 8'd1;
				jtag_shift_word(1'b1, r.data);
			end
			op_host_wr: begin
				ref_mem[r.addr] = r.data;
				host_write(r.addr, r.data);
			end
			op_host_rd: host_read_burst(r.addr, 1);
			op_both_wr: begin
				ref_mem[ref_addr] = r.data;
				ref_addr = ref_addr + 8'd1;
				fork
					jtag_shift_word(1'b1, r.data);
					begin
						repeat (33 * 8 + 2) @(posedge clk48m); // just before the update strobe
						host_read_burst(r.addr, 3);
					end
				join
			end
			op_both_rd: begin
				ref_addr = r.addr;
				tbl[i].exp = ref_mem[ref_addr];
				fork
					jtag_read(r.addr, tbl[i].exp);
					begin
						repeat (33 * 8 + 2) @(posedge clk48m);
						host_read_burst(8'h10, 3);
					end
				join
				// round robin serves the waiting debug read before the last host read
				check_flag(dbg_rvalid_cyc < host_grant_cyc, 1'b1,
					"debug read served between host reads");
			end
			default: $display("unknown operation in row %0d", i);
		endcase
	endtask

	initial begin
		jrstn    <= 1'b0;
		jtck     <= 1'b0;
		jtdi     <= 1'b0;
		jshift   <= 1'b0;
		jupdate  <= 1'b0;
		jce1     <= 1'b0;
		jce2     <= 1'b0;
		host_req <= 1'b0;
		host_cmd <= '0;
		ref_addr = 8'h00;
		dbg_got  = 1'b0;
		build_table();
		repeat (3) @(posedge clk48m);
		jrstn <= 1'b1;
		@(negedge clk48m);
		check_flag(host_grant, 1'b0, "host_grant after reset");
		check_flag(host_rvalid, 1'b0, "host_rvalid after reset");
		check_flag(dbg_rvalid, 1'b0, "dbg_rvalid after reset");
		check_flag(dbg_overrun, 1'b0, "dbg_overrun after reset");
		@(posedge clk48m);

		for (int i = 0; i < num_rows; i++) begin
			apply_row(i);
		end
		repeat (4) @(posedge clk48m);
		check_flag(overrun_seen, 1'b0, "dbg_overrun seen during run");
		err_assert = UUT.u_arbiter.u_props.assert_errs;

		$display("errors: %0d wrong values, %0d missing responses, %0d assertion failures",
			err_value, err_missing, err_assert);
		if (err_value == 0 && err_missing == 0 && err_assert == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* files.f */
logic/dbg_pkg.sv
logic/jtag_dr_capture.sv
logic/dbg_cmd_decode.sv
logic/mem_arbiter.sv
logic/dbg_ram.sv
logic/dbg_subsys_top.sv
sim/dbg_subsys_props.sv
sim/dbg_subsys_tb.sv
